// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter
    import cart_bus_pkg::*;
(
    input wire logic sys,
    input wire logic arst_n,
    input wire logic cpu_req,
    input wire logic host_req,
    input wire bus_req_t cpu_bus,
    input wire bus_req_t host_bus,
    input wire bus_rsp_t slv_rsp,
    output bus_rsp_t cpu_rsp,
    output bus_rsp_t host_rsp,
    output logic slv_request,
    output bus_req_t slv_bus
);

    arb_state_e state;
    logic grant_host;
    logic pick_host;
    bus_req_t bus_q;

    // Host wins when alone, or on a tie if the CPU had the last grant
    assign pick_host = host_req && (!cpu_req || !grant_host);

    always_ff @(posedge sys or negedge arst_n) begin
        if (!arst_n) begin
            state <= arb_idle;
            grant_host <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (cpu_req || host_req) begin
                        state <= arb_issue;
                        grant_host <= pick_host;
                    end
                end
                arb_issue: state <= arb_wait_ack;
                arb_wait_ack: begin
                    if (slv_rsp.ack) begin
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    always_ff @(posedge sys) begin
        if (state == arb_idle) begin
            bus_q <= pick_host ? host_bus : cpu_bus;
        end
    end

    assign slv_request = (state == arb_issue);
    assign slv_bus = bus_q;

    always_comb begin
        cpu_rsp = '0;
        host_rsp = '0;
        if (grant_host) begin
            host_rsp = slv_rsp;
        end else begin
            cpu_rsp = slv_rsp;
        end
    end

    single_strobe: assert property (@(posedge sys) disable iff (!arst_n)
        slv_request |=> !slv_request);

    ack_in_wait: assert property (@(posedge sys) disable iff (!arst_n)
        slv_rsp.ack |-> (state == arb_wait_ack));

endmodule

`default_nettype wire

// ==== hdl/cart_bus_pkg.sv ====
`default_nettype none

package cart_bus_pkg;

    // A zero wmask marks a read
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] wdata;
        logic [3:0] wmask;
    } bus_req_t;

    typedef struct packed {
        logic ack;
        logic [31:0] rdata;
    } bus_rsp_t;

    // Register index, address bits 4 to 2
    typedef enum logic [2:0] {
        reg_scr,
        reg_ddipl_offset,
        reg_save_offset,
        reg_command,
        reg_data_0,
        reg_data_1,
        reg_version,
        reg_reconfigure
    } reg_id_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_issue,
        arb_wait_ack
    } arb_state_e;

endpackage

`default_nettype wire

// ==== hdl/cart_cfg_pkg.sv ====
`default_nettype none

package cart_cfg_pkg;

    // Ordered to match bits 6 to 0 of the scr word
    typedef struct packed {
        logic skip_bootloader;
        logic flashram_enabled;
        logic sram_banked;
        logic sram_enabled;
        logic dd_enabled;
        logic sdram_writable;
        logic sdram_switch;
    } cfg_ctrl_t;

    typedef struct packed {
        logic cpu_ready;
        logic cpu_busy;
        logic cmd_error;
    } cfg_status_t;

    typedef struct packed {
        logic [7:0] cmd;
        logic [1:0][31:0] data;
    } mailbox_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_armed,
        seq_reconfig
    } seq_state_e;

endpackage

`default_nettype wire

// ==== hdl/cart_cfg_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cart_consts.svh"

module cart_cfg_top
    import cart_bus_pkg::*, cart_cfg_pkg::*;
(
    input wire logic sys,
    input wire logic arst_n,
    input wire logic cpu_req,
    input wire bus_req_t cpu_bus,
    input wire logic host_req,
    input wire bus_req_t host_bus,
    input wire logic soft_reset,
    input wire logic cmd_wr,
    input wire logic [7:0] cmd_in,
    input wire logic data_wr,
    input wire logic data_idx,
    input wire logic [31:0] data_in,
    output bus_rsp_t cpu_rsp,
    output bus_rsp_t host_rsp,
    output cfg_ctrl_t ctrl,
    output cfg_status_t status,
    output logic [`OFFSET_W-1:0] ddipl_offset,
    output logic [`OFFSET_W-1:0] save_offset,
    output mailbox_t mbox,
    output logic reconfig
);

    logic slv_request;
    bus_req_t slv_bus;
    bus_rsp_t slv_rsp;
    logic [1:0] data_write;
    logic [31:0] wdata;
    logic cmd_request;
    logic reconfig_trigger;

    bus_arbiter bus_arbiter_i (.*);

    cpu_cfg cpu_cfg_i (
        .*,
        .request(slv_request),
        .bus(slv_bus),
        .rsp(slv_rsp)
    );

    cmd_mailbox cmd_mailbox_i (.*);

    reconfig_sequencer reconfig_sequencer_i (.*);

endmodule

`default_nettype wire

// ==== hdl/cmd_mailbox.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmd_mailbox
    import cart_cfg_pkg::*;
(
    input wire logic sys,
    input wire logic arst_n,
    input wire logic cmd_wr,
    input wire logic [7:0] cmd_in,
    input wire logic data_wr,
    input wire logic data_idx,
    input wire logic [31:0] data_in,
    input wire logic [1:0] data_write,
    input wire logic [31:0] wdata,
    output mailbox_t mbox,
    output logic cmd_request
);

    always_ff @(posedge sys or negedge arst_n) begin
        if (!arst_n) begin
            cmd_request <= 1'b0;
        end else begin
            cmd_request <= cmd_wr;
        end
    end

    // Bus side has priority over the console on each data word
    always_ff @(posedge sys) begin
        if (cmd_wr) begin
            mbox.cmd <= cmd_in;
        end
        if (data_write[0]) begin
            mbox.data[0] <= wdata;
        end else if (data_wr && !data_idx) begin
            mbox.data[0] <= data_in;
        end
        if (data_write[1]) begin
            mbox.data[1] <= wdata;
        end else if (data_wr && data_idx) begin
            mbox.data[1] <= data_in;
        end
    end

    one_word_per_access: assert property (@(posedge sys) disable iff (!arst_n)
        data_write != 2'b11);

endmodule

`default_nettype wire

// ==== hdl/cpu_cfg.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cart_consts.svh"

module cpu_cfg
    import cart_bus_pkg::*, cart_cfg_pkg::*;
(
    input wire logic sys,
    input wire logic arst_n,
    input wire logic request,
    input wire bus_req_t bus,
    input wire logic soft_reset,
    input wire logic cmd_request,
    input wire mailbox_t mbox,
    output bus_rsp_t rsp,
    output logic [1:0] data_write,
    output logic [31:0] wdata,
    output cfg_ctrl_t ctrl,
    output cfg_status_t status,
    output logic [`OFFSET_W-1:0] ddipl_offset,
    output logic [`OFFSET_W-1:0] save_offset,
    output logic reconfig_trigger
);

    reg_id_e reg_id;
    logic full_mask;
    logic ack_q;

    assign reg_id = reg_id_e'(bus.address[4:2]);
    assign full_mask = &bus.wmask;

    always_ff @(posedge sys or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= request;
        end
    end

    // ***********************************************************
    // Read path, valid only while ack is high
    // ***********************************************************

    always_comb begin
        rsp.ack = ack_q;
        rsp.rdata = 32'd0;
        if (ack_q) begin
            case (reg_id)
                reg_scr: rsp.rdata = {
                    status.cpu_ready,
                    status.cpu_busy,
                    1'b0,
                    status.cmd_error,
                    21'd0,
                    ctrl
                };
                reg_ddipl_offset: rsp.rdata = {{(32-`OFFSET_W){1'b0}}, ddipl_offset};
                reg_save_offset: rsp.rdata = {{(32-`OFFSET_W){1'b0}}, save_offset};
                reg_command: rsp.rdata = {24'd0, mbox.cmd};
                reg_data_0: rsp.rdata = mbox.data[0];
                reg_data_1: rsp.rdata = mbox.data[1];
                reg_version: rsp.rdata = `CART_VERSION;
                reg_reconfigure: rsp.rdata = `RECONFIG_MAGIC;
                default: rsp.rdata = 32'd0;
            endcase
        end
    end

    // Data words live in the mailbox, only full-word writes go there
    assign wdata = bus.wdata;

    always_comb begin
        data_write = 2'b00;
        if (request && full_mask) begin
            data_write[0] = (reg_id == reg_data_0);
            data_write[1] = (reg_id == reg_data_1);
        end
    end

    // ***********************************************************
    // Write path
    // ***********************************************************

    always_ff @(posedge sys or negedge arst_n) begin
        if (!arst_n) begin
            ctrl <= '0;
            status <= '0;
            ddipl_offset <= `DDIPL_OFFSET_RST;
            save_offset <= `SAVE_OFFSET_RST;
            reconfig_trigger <= 1'b0;
        end else begin
            if (soft_reset) begin
                ctrl.sdram_switch <= ctrl.skip_bootloader;
                ctrl.sdram_writable <= 1'b0;
            end
            if (cmd_request) begin
                status.cpu_busy <= 1'b1;
            end
            // Bus writes come last so they win over the events above
            if (request) begin
                case (reg_id)
                    reg_scr: begin
                        if (bus.wmask[3]) begin
                            status <= cfg_status_t'({bus.wdata[31:30], bus.wdata[28]});
                        end
                        if (bus.wmask[0]) begin
                            ctrl <= cfg_ctrl_t'(bus.wdata[6:0]);
                        end
                    end
                    reg_ddipl_offset: begin
                        if (full_mask) begin
                            ddipl_offset <= bus.wdata[`OFFSET_W-1:0];
                        end
                    end
                    reg_save_offset: begin
                        if (full_mask) begin
                            save_offset <= bus.wdata[`OFFSET_W-1:0];
                        end
                    end
                    reg_reconfigure: begin
                        if (full_mask && (bus.wdata == `RECONFIG_MAGIC)) begin
                            reconfig_trigger <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // No new strobe may overlap the ack of the previous one
    ack_follows_request: assert property (@(posedge sys) disable iff (!arst_n)
        request |=> (rsp.ack && !request));

    trigger_sticky: assert property (@(posedge sys) disable iff (!arst_n)
        reconfig_trigger |=> reconfig_trigger);

endmodule

`default_nettype wire

// ==== hdl/reconfig_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module reconfig_sequencer
    import cart_cfg_pkg::*;
(
    input wire logic sys,
    input wire logic arst_n,
    input wire logic reconfig_trigger,
    output logic reconfig
);

    seq_state_e state;
    logic [1:0] phase;

    // Phase counter stands in for the slow update clock, sys / 4
    always_ff @(posedge sys or negedge arst_n) begin
        if (!arst_n) begin
            state <= seq_idle;
            phase <= 2'd0;
        end else begin
            phase <= phase + 2'd1;
            case (state)
                seq_idle: begin
                    if (reconfig_trigger) begin
                        state <= seq_armed;
                    end
                end
                seq_armed: begin
                    if (phase == 2'd1) begin
                        state <= seq_reconfig;
                    end
                end
                default: ;
            endcase
        end
    end

    assign reconfig = (state == seq_reconfig);

endmodule

`default_nettype wire

// ==== include/cart_consts.svh ====
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// Identification word returned by the version register
`define CART_VERSION 32'h4346_0102

// Only this exact word arms the reconfiguration sequencer
`define RECONFIG_MAGIC 32'h5253_5446

// ***********************************************************
// Memory offsets
// ***********************************************************

`define OFFSET_W 26

`define DDIPL_OFFSET_RST 26'h3BE_0000
`define SAVE_OFFSET_RST 26'h3FE_0000

`endif

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f vlog.f --top-module cart_cfg_tb -o cart_cfg_sim

sim_out=$(./obj_dir/cart_cfg_sim)
echo "$sim_out"

if grep -qx "Test OK" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== verif/cart_cfg_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cart_consts.svh"

module cart_cfg_tb
    import cart_bus_pkg::*, cart_cfg_pkg::*;
();

    localparam int ACK_TIMEOUT = 20;
    localparam int RECONFIG_LIMIT = 5;

    logic sys;
    logic arst_n;
    logic cpu_req;
    logic host_req;
    bus_req_t cpu_bus;
    bus_req_t host_bus;
    logic soft_reset;
    logic cmd_wr;
    logic [7:0] cmd_in;
    logic data_wr;
    logic data_idx;
    logic [31:0] data_in;
    bus_rsp_t cpu_rsp;
    bus_rsp_t host_rsp;
    cfg_ctrl_t ctrl;
    cfg_status_t status;
    logic [`OFFSET_W-1:0] ddipl_offset;
    logic [`OFFSET_W-1:0] save_offset;
    mailbox_t mbox;
    logic reconfig;

    int seq_errors = 0;
    int monitor_errors = 0;
    int prop_errors = 0;
    int cpu_accesses = 0;
    int host_accesses = 0;
    int cpu_acks = 0;
    int host_acks = 0;
    logic contend = 1'b0;
    logic magic_sent = 1'b0;
    logic have_last = 1'b0;
    logic last_host = 1'b0;
    logic [15:0] lfsr = 16'd56;

    // Scoreboard
    logic [`OFFSET_W-1:0] exp_ddipl;
    logic [`OFFSET_W-1:0] exp_save;
    cfg_ctrl_t exp_ctrl;
    cfg_status_t exp_status;
    logic [7:0] exp_cmd;
    logic [31:0] exp_data0;
    logic [31:0] exp_data1;

    cart_cfg_top dut_i (.*);

    initial begin
        sys = 1'b0;
        forever #5 sys = ~sys;
    end

    initial begin
        #200000;
        $display("Watchdog expired before the test sequence completed");
        finish_run(1'b1);
    end

    // ************************************************************
    // Helpers
    // ************************************************************

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] scr_word(input cfg_status_t st, input cfg_ctrl_t ct);
        return {st.cpu_ready, st.cpu_busy, 1'b0, st.cmd_error, 21'd0, ct};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        assert (got === exp) else begin
            seq_errors++;
            $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            seq_errors++;
            $display("Failure at %0t: %s", $time, what);
        end
    endtask

    // Holds req until the master's own ack, latency counts the request cycle
    task automatic bus_access(input logic host, input reg_id_e idx, input logic [31:0] wdata,
            input logic [3:0] wmask, output logic [31:0] rdata, output int latency);
        bus_req_t req;
        bus_rsp_t rsp;
        int waited;
        req.address = {27'd0, idx, 2'b00};
        req.wdata = wdata;
        req.wmask = wmask;
        rsp = '0;
        rdata = '0;
        latency = 0;
        waited = 0;
        @(negedge sys);
        if (host) begin
            host_bus = req;
            host_req = 1'b1;
            host_accesses++;
        end else begin
            cpu_bus = req;
            cpu_req = 1'b1;
            cpu_accesses++;
        end
        while (!rsp.ack && waited < ACK_TIMEOUT) begin
            @(negedge sys);
            waited++;
            rsp = host ? host_rsp : cpu_rsp;
        end
        if (rsp.ack) begin
            rdata = rsp.rdata;
            latency = waited + 1;
        end else begin
            seq_errors++;
            $display("Timeout at %0t: no bus ack for the %s access", $time,
                host ? "host" : "cpu");
        end
        if (host) begin
            host_req = 1'b0;
        end else begin
            cpu_req = 1'b0;
        end
    endtask

    task automatic bus_write(input logic host, input reg_id_e idx, input logic [31:0] wdata,
            input logic [3:0] wmask);
        logic [31:0] unused_rdata;
        int unused_latency;
        bus_access(host, idx, wdata, wmask, unused_rdata, unused_latency);
    endtask

    task automatic bus_read_check(input logic host, input reg_id_e idx,
            input logic [31:0] exp, input string name);
        logic [31:0] rdata;
        int latency;
        bus_access(host, idx, 32'd0, 4'h0, rdata, latency);
        check_value(name, rdata, exp);
    endtask

    task automatic finish_run(input logic aborted);
        $display("Errors: %0d sequence, %0d monitor, %0d property",
            seq_errors, monitor_errors, prop_errors);
        if (aborted || (seq_errors + monitor_errors + prop_errors) != 0) begin
            $display("Test FAILED");
        end else begin
            $display("Test OK");
        end
        $finish;
    endtask

    // ************************************************************
    // Monitors
    // ************************************************************

    always @(negedge sys) begin
        if (arst_n) begin
            assert (cpu_rsp.ack || cpu_rsp.rdata == 32'd0) else begin
                monitor_errors++;
                $display("** Error at %0t: cpu_rsp.rdata = 0x%08h, expected 0x00000000",
                    $time, cpu_rsp.rdata);
            end
            assert (host_rsp.ack || host_rsp.rdata == 32'd0) else begin
                monitor_errors++;
                $display("** Error at %0t: host_rsp.rdata = 0x%08h, expected 0x00000000",
                    $time, host_rsp.rdata);
            end
            if (cpu_rsp.ack) begin
                cpu_acks++;
            end
            if (host_rsp.ack) begin
                host_acks++;
            end
            // Under contention the grant owner must alternate
            if (contend && (cpu_rsp.ack || host_rsp.ack)) begin
                if (have_last) begin
                    assert (host_rsp.ack != last_host) else begin
                        monitor_errors++;
                        $display("Grant did not alternate at %0t", $time);
                    end
                end
                last_host = host_rsp.ack;
                have_last = 1'b1;
            end
        end
        if (!contend) begin
            have_last = 1'b0;
        end
    end

    one_ack_owner: assert property (@(posedge sys) disable iff (!arst_n)
        !(cpu_rsp.ack && host_rsp.ack))
    else begin
        prop_errors++;
        $display("Both masters saw an ack in the same cycle at %0t", $time);
    end

    cpu_ack_pulse: assert property (@(posedge sys) disable iff (!arst_n)
        cpu_rsp.ack |=> !cpu_rsp.ack)
    else begin
        prop_errors++;
        $display("CPU ack held longer than one cycle at %0t", $time);
    end

    host_ack_pulse: assert property (@(posedge sys) disable iff (!arst_n)
        host_rsp.ack |=> !host_rsp.ack)
    else begin
        prop_errors++;
        $display("Host ack held longer than one cycle at %0t", $time);
    end

    reconfig_held: assert property (@(posedge sys) disable iff (!arst_n)
        reconfig |=> reconfig)
    else begin
        prop_errors++;
        $display("reconfig fell without reset at %0t", $time);
    end

    reconfig_needs_magic: assert property (@(posedge sys) disable iff (!arst_n)
        !magic_sent |-> !reconfig)
    else begin
        prop_errors++;
        $display("reconfig rose before the magic write at %0t", $time);
    end

    // ************************************************************
    // Test sequence
    // ************************************************************

    initial begin
        logic [31:0] word;
        logic [31:0] word2;
        logic [31:0] r_cpu;
        logic [31:0] r_host;
        int lat;
        int lat_host;
        int waited;
        logic pick;
        cpu_req = 1'b0;
        host_req = 1'b0;
        cpu_bus = '0;
        host_bus = '0;
        soft_reset = 1'b0;
        cmd_wr = 1'b0;
        cmd_in = 8'd0;
        data_wr = 1'b0;
        data_idx = 1'b0;
        data_in = 32'd0;
        arst_n = 1'b0;
        repeat (4) @(negedge sys);
        arst_n = 1'b1;

        // Reset values
        exp_ddipl = `DDIPL_OFFSET_RST;
        exp_save = `SAVE_OFFSET_RST;
        exp_ctrl = '0;
        exp_status = '0;
        check_value("reconfig", {31'd0, reconfig}, 32'd0);
        check_value("cpu_rsp.ack", {31'd0, cpu_rsp.ack}, 32'd0);
        check_value("host_rsp.ack", {31'd0, host_rsp.ack}, 32'd0);
        check_value("ctrl", {25'd0, ctrl}, 32'd0);
        check_value("status", {29'd0, status}, 32'd0);
        check_value("ddipl_offset", {6'd0, ddipl_offset}, {6'd0, exp_ddipl});
        check_value("save_offset", {6'd0, save_offset}, {6'd0, exp_save});
        bus_read_check(1'b0, reg_version, `CART_VERSION, "version");
        bus_read_check(1'b1, reg_ddipl_offset, {6'd0, exp_ddipl}, "ddipl_offset");
        bus_read_check(1'b0, reg_save_offset, {6'd0, exp_save}, "save_offset");
        bus_read_check(1'b1, reg_scr, 32'd0, "scr");

        // Offsets from either master, uncontended
        for (int i = 0; i < 6; i++) begin
            random_bits(1, word);
            pick = word[0];
            random_bits(32, word);
            if (i % 2 == 1) begin
                exp_save = word[`OFFSET_W-1:0];
                bus_access(pick, reg_save_offset, word, 4'hf, r_cpu, lat);
                bus_read_check(!pick, reg_save_offset, {6'd0, exp_save}, "save_offset");
            end else begin
                exp_ddipl = word[`OFFSET_W-1:0];
                bus_access(pick, reg_ddipl_offset, word, 4'hf, r_cpu, lat);
                bus_read_check(!pick, reg_ddipl_offset, {6'd0, exp_ddipl}, "ddipl_offset");
            end
            check_value("write latency", lat, 32'd3);
            check_value("ddipl_offset", {6'd0, ddipl_offset}, {6'd0, exp_ddipl});
            check_value("save_offset", {6'd0, save_offset}, {6'd0, exp_save});
        end

        // Byte lanes of scr
        random_bits(32, word);
        exp_ctrl = cfg_ctrl_t'(word[6:0]);
        bus_write(1'b0, reg_scr, word, 4'b0001);
        bus_read_check(1'b1, reg_scr, scr_word(exp_status, exp_ctrl), "scr");
        random_bits(32, word);
        exp_status = cfg_status_t'({word[31], word[30], word[28]});
        bus_write(1'b1, reg_scr, word, 4'b1000);
        bus_read_check(1'b0, reg_scr, scr_word(exp_status, exp_ctrl), "scr");
        exp_ctrl.skip_bootloader = 1'b1;
        exp_ctrl.sdram_writable = 1'b1;
        exp_ctrl.sdram_switch = 1'b0;
        bus_write(1'b0, reg_scr, {25'd0, exp_ctrl}, 4'b0001);
        @(negedge sys);
        soft_reset = 1'b1;
        @(negedge sys);
        soft_reset = 1'b0;
        exp_ctrl.sdram_switch = exp_ctrl.skip_bootloader;
        exp_ctrl.sdram_writable = 1'b0;
        check_value("ctrl", {25'd0, ctrl}, {25'd0, exp_ctrl});
        bus_read_check(1'b1, reg_scr, scr_word(exp_status, exp_ctrl), "scr");

        // Mailbox, console side first
        exp_status = '0;
        bus_write(1'b0, reg_scr, 32'd0, 4'b1000);
        random_bits(8, word);
        exp_cmd = word[7:0];
        @(negedge sys);
        cmd_wr = 1'b1;
        cmd_in = exp_cmd;
        @(negedge sys);
        cmd_wr = 1'b0;
        waited = 0;
        while (!status.cpu_busy && waited < 4) begin
            @(negedge sys);
            waited++;
        end
        check_true(status.cpu_busy, "cpu_busy not set after a console command");
        exp_status.cpu_busy = 1'b1;
        bus_read_check(1'b1, reg_command, {24'd0, exp_cmd}, "command");
        bus_read_check(1'b0, reg_scr, scr_word(exp_status, exp_ctrl), "scr");
        random_bits(32, word);
        exp_data0 = word;
        @(negedge sys);
        data_wr = 1'b1;
        data_idx = 1'b0;
        data_in = word;
        @(negedge sys);
        data_wr = 1'b0;
        bus_read_check(1'b0, reg_data_0, exp_data0, "data_0");
        random_bits(32, word);
        exp_data1 = word;
        bus_write(1'b1, reg_data_1, word, 4'hf);
        check_value("mbox.data[1]", mbox.data[1], exp_data1);
        random_bits(32, word);
        bus_write(1'b0, reg_data_1, word, 4'b0011);
        check_value("mbox.data[1]", mbox.data[1], exp_data1);
        bus_read_check(1'b1, reg_data_1, exp_data1, "data_1");

        // Both masters at once, each re-requesting right after its own ack
        contend = 1'b1;
        for (int i = 0; i < 4; i++) begin
            random_bits(32, word);
            random_bits(32, word2);
            exp_ddipl = word[`OFFSET_W-1:0];
            exp_save = word2[`OFFSET_W-1:0];
            fork
                begin
                    bus_access(1'b0, reg_ddipl_offset, word, 4'hf, r_cpu, lat);
                    bus_access(1'b0, reg_ddipl_offset, 32'd0, 4'h0, r_cpu, lat);
                end
                begin
                    bus_access(1'b1, reg_save_offset, word2, 4'hf, r_host, lat_host);
                    bus_access(1'b1, reg_save_offset, 32'd0, 4'h0, r_host, lat_host);
                end
            join
            check_value("cpu_rsp.rdata", r_cpu, {6'd0, exp_ddipl});
            check_value("host_rsp.rdata", r_host, {6'd0, exp_save});
        end
        contend = 1'b0;

        // Reconfiguration
        random_bits(32, word);
        bus_write(1'b1, reg_reconfigure, `RECONFIG_MAGIC ^ (word | 32'd1), 4'hf);
        repeat (10) @(negedge sys);
        check_value("reconfig", {31'd0, reconfig}, 32'd0);
        bus_read_check(1'b0, reg_reconfigure, `RECONFIG_MAGIC, "reconfigure");
        magic_sent = 1'b1;
        bus_write(1'b0, reg_reconfigure, `RECONFIG_MAGIC, 4'hf);
        waited = 0;
        while (!reconfig && waited < RECONFIG_LIMIT) begin
            @(negedge sys);
            waited++;
        end
        check_true(reconfig, "reconfig did not rise within 5 cycles of the magic write");
        repeat (12) @(negedge sys);
        check_value("reconfig", {31'd0, reconfig}, 32'd1);

        check_value("cpu ack count", cpu_acks, cpu_accesses);
        check_value("host ack count", host_acks, host_accesses);
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
hdl/cart_bus_pkg.sv
hdl/cart_cfg_pkg.sv
hdl/bus_arbiter.sv
hdl/cpu_cfg.sv
hdl/cmd_mailbox.sv
hdl/reconfig_sequencer.sv
hdl/cart_cfg_top.sv
verif/cart_cfg_tb.sv
